//--- common/calc_macros.svh
`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// Operands and result
`define CALC_DATA_W 32

// Mailbox register address
`define CALC_ADDR_W 8

////////////////////////////////////////////////////////////
// Mailbox register map
////////////////////////////////////////////////////////////

// Opcode write also launches the operation
`define CALC_ADDR_OP 8'd0
// Read-only result
`define CALC_ADDR_RESULT 8'd1
// First operand
`define CALC_ADDR_A 8'd16
// Second operand
`define CALC_ADDR_B 8'd20

`endif

//--- common/calcPkg.sv
package calcPkg;

	////////////////////////////////////////////////////////////
	// Arithmetic operation codes
	////////////////////////////////////////////////////////////

	// Encoding matches the low two bits written to the opcode register
	typedef enum logic [1:0]
	{
		opAdd = 2'd0,
		opSub = 2'd1,
		opMul = 2'd2,
		opDiv = 2'd3
	} calcOp;

	////////////////////////////////////////////////////////////
	// Keystroke sequencer phases
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0]
	{
		stIdle    = 4'd0,
		stNum1    = 4'd1,
		stNum2    = 4'd2,
		stOpSel   = 4'd3,
		stStoreA  = 4'd4,
		stStoreB  = 4'd5,
		stStoreOp = 4'd6,
		stDone    = 4'd7
	} seqState;

	// Source of the mailbox write data
	typedef enum logic [1:0]
	{
		selNone = 2'd0,
		selNum1 = 2'd1,
		selNum2 = 2'd2,
		selOp   = 2'd3
	} storeSel;

endpackage

//--- common/calcBusIf.sv
`timescale 1ns/1ns
`include "calc_macros.svh"

interface calcBusIf import calcPkg::*; ();

	// Phase levels from the sequencer
	logic clearOps;
	logic capNum1;
	logic capNum2;
	logic capOp;
	logic showResult;

	// Register write path
	storeSel sel;
	logic [`CALC_ADDR_W-1:0] addr;
	logic wrEn;
	logic [`CALC_DATA_W-1:0] wrData;

	// Register read path, follows addr
	logic [`CALC_DATA_W-1:0] rdData;

	modport seq
	(
		output clearOps, capNum1, capNum2, capOp, showResult,
		output sel, addr, wrEn
	);

	modport entry
	(
		input clearOps, capNum1, capNum2, capOp, sel,
		output wrData
	);

	modport mailbox
	(
		input addr, wrEn, wrData,
		output rdData
	);

endinterface

//--- sequencer/calcSequencer.sv
`timescale 1ns/1ns
`include "calc_macros.svh"

module calcSequencer import calcPkg::*;
(
	input logic clk,
	input logic arstN,
	input logic digitStrobe,
	input logic keyPress,
	calcBusIf.seq bus
);

	seqState state;
	seqState nextState;

	// Key level from the previous cycle
	logic keyPrev;
	// Registered key edge, one cycle after the rising edge
	logic keyEdgeQ;
	// Phases that react to the key
	logic acceptKey;

	////////////////////////////////////////////////////////////
	// Key edge detection
	////////////////////////////////////////////////////////////

	// Store phases and idle drop any key press
	assign acceptKey = (state == stNum1) || (state == stNum2) ||
		(state == stOpSel) || (state == stDone);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			keyPrev  <= 1'b0;
			keyEdgeQ <= 1'b0;
		end
		else
		begin
			keyPrev <= keyPress;
			// Digit in the same cycle wins, edge is lost
			keyEdgeQ <= acceptKey && keyPress && !keyPrev && !digitStrobe;
		end
	end

	////////////////////////////////////////////////////////////
	// Phase register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			state <= stIdle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			// Single clearing cycle
			stIdle:
				nextState = stNum1;
			stNum1:
				if (keyEdgeQ)
					nextState = stNum2;
			stNum2:
				if (keyEdgeQ)
					nextState = stOpSel;
			stOpSel:
				if (keyEdgeQ)
					nextState = stStoreA;
			// Three fixed store cycles
			stStoreA:
				nextState = stStoreB;
			stStoreB:
				nextState = stStoreOp;
			stStoreOp:
				nextState = stDone;
			// Result shown until the next key
			stDone:
				if (keyEdgeQ)
					nextState = stIdle;
			default:
				nextState = stIdle;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Output decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		bus.clearOps   = 1'b0;
		bus.capNum1    = 1'b0;
		bus.capNum2    = 1'b0;
		bus.capOp      = 1'b0;
		bus.showResult = 1'b0;
		bus.sel        = selNone;
		// Parked on the result register
		bus.addr       = `CALC_ADDR_RESULT;
		bus.wrEn       = 1'b0;
		case (state)
			stIdle:
				bus.clearOps = 1'b1;
			stNum1:
				bus.capNum1 = 1'b1;
			stNum2:
				bus.capNum2 = 1'b1;
			stOpSel:
				bus.capOp = 1'b1;
			stStoreA:
			begin
				bus.addr = `CALC_ADDR_A;
				bus.sel  = selNum1;
				bus.wrEn = 1'b1;
			end
			stStoreB:
			begin
				bus.addr = `CALC_ADDR_B;
				bus.sel  = selNum2;
				bus.wrEn = 1'b1;
			end
			stStoreOp:
			begin
				bus.addr = `CALC_ADDR_OP;
				bus.sel  = selOp;
				bus.wrEn = 1'b1;
			end
			stDone:
				bus.showResult = 1'b1;
			default:
				bus.clearOps = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// No write outside the store phases
	wrOnlyInStore: assert property (@(posedge clk) disable iff (!arstN)
		bus.wrEn |-> (state inside {stStoreA, stStoreB, stStoreOp}));

	// Phase levels are exclusive
	oneCapture: assert property (@(posedge clk) disable iff (!arstN)
		$onehot0({bus.capNum1, bus.capNum2, bus.capOp, bus.showResult}));

endmodule

//--- verilog/operandEntry.sv
`timescale 1ns/1ns
`include "calc_macros.svh"

module operandEntry import calcPkg::*;
(
	input logic clk,
	input logic arstN,
	input logic digitStrobe,
	input logic [3:0] digit,
	input calcOp opCode,
	calcBusIf.entry bus
);

	// Decimal accumulators
	logic [`CALC_DATA_W-1:0] num1;
	logic [`CALC_DATA_W-1:0] num2;
	// Captured operator
	calcOp opReg;

	// Ten times the value plus one digit, wraps at the data width
	function automatic logic [`CALC_DATA_W-1:0] appendDigit(
		input logic [`CALC_DATA_W-1:0] value,
		input logic [3:0] d
	);
		logic [`CALC_DATA_W-1:0] dExt;
		dExt = {{(`CALC_DATA_W-4){1'b0}}, d};
		return (value << 3) + (value << 1) + dExt;
	endfunction

	////////////////////////////////////////////////////////////
	// Operand accumulation
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			num1 <= '0;
			num2 <= '0;
		end
		else if (bus.clearOps)
		begin
			// New session
			num1 <= '0;
			num2 <= '0;
		end
		else if (digitStrobe)
		begin
			// Only the active operand takes the digit
			if (bus.capNum1)
				num1 <= appendDigit(num1, digit);
			if (bus.capNum2)
				num2 <= appendDigit(num2, digit);
		end
	end

	// Operator tracks the input during its phase
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			opReg <= opAdd;
		else if (bus.capOp)
			opReg <= opCode;
	end

	////////////////////////////////////////////////////////////
	// Write data select
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (bus.sel)
			selNum1:
				bus.wrData = num1;
			selNum2:
				bus.wrData = num2;
			// Opcode in the low bits
			selOp:
				bus.wrData = {{(`CALC_DATA_W-2){1'b0}}, opReg};
			default:
				bus.wrData = '0;
		endcase
	end

	// Keypad gives decimal digits only
	digitRange: assert property (@(posedge clk) disable iff (!arstN)
		digitStrobe |-> (digit <= 4'd9));

endmodule

//--- alu/calcMailbox.sv
`timescale 1ns/1ns
`include "calc_macros.svh"

module calcMailbox import calcPkg::*;
(
	input logic clk,
	input logic arstN,
	calcBusIf.mailbox bus
);

	// Operand registers
	logic [`CALC_DATA_W-1:0] regA;
	logic [`CALC_DATA_W-1:0] regB;
	// Last opcode written
	calcOp opQ;
	// Opcode on the write bus
	calcOp wrOp;
	// Arithmetic output and its register
	logic [`CALC_DATA_W-1:0] aluOut;
	logic [`CALC_DATA_W-1:0] resultQ;

	assign wrOp = calcOp'(bus.wrData[1:0]);

	////////////////////////////////////////////////////////////
	// Arithmetic unit
	////////////////////////////////////////////////////////////

	// Operands are already stored when the opcode arrives
	always_comb
	begin
		case (wrOp)
			opAdd:
				aluOut = regA + regB;
			opSub:
				aluOut = regA - regB;
			// Low half of the product
			opMul:
				aluOut = regA * regB;
			opDiv:
				// Zero divisor saturates
				if (regB == '0)
					aluOut = '1;
				else
					aluOut = regA / regB;
			default:
				aluOut = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Register writes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			regA    <= '0;
			regB    <= '0;
			opQ     <= opAdd;
			resultQ <= '0;
		end
		else if (bus.wrEn)
		begin
			case (bus.addr)
				`CALC_ADDR_A:
					regA <= bus.wrData;
				`CALC_ADDR_B:
					regB <= bus.wrData;
				`CALC_ADDR_OP:
				begin
					// Opcode write launches the operation
					opQ     <= wrOp;
					resultQ <= aluOut;
				end
				default:
					regA <= regA;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (bus.addr)
			`CALC_ADDR_A:
				bus.rdData = regA;
			`CALC_ADDR_B:
				bus.rdData = regB;
			`CALC_ADDR_OP:
				bus.rdData = {{(`CALC_DATA_W-2){1'b0}}, opQ};
			`CALC_ADDR_RESULT:
				bus.rdData = resultQ;
			default:
				bus.rdData = '0;
		endcase
	end

	// Only mapped registers are written
	wrMapped: assert property (@(posedge clk) disable iff (!arstN)
		bus.wrEn |-> (bus.addr inside {`CALC_ADDR_A, `CALC_ADDR_B, `CALC_ADDR_OP}));

endmodule

//--- verilog/calcTop.sv
`timescale 1ns/1ns
`include "calc_macros.svh"

module calcTop import calcPkg::*;
(
	input logic clk,
	input logic arstN,
	input logic digitStrobe,
	input logic [3:0] digit,
	input logic keyPress,
	input calcOp opCode,
	output logic num1Active,
	output logic num2Active,
	output logic opActive,
	output logic resultValid,
	output logic [`CALC_DATA_W-1:0] result
);

	// Shared control and register path
	calcBusIf bus ();

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////

	// Keystroke phases and store cycles
	calcSequencer i_calcSequencer
	(
		.clk         (clk),
		.arstN       (arstN),
		.digitStrobe (digitStrobe),
		.keyPress    (keyPress),
		.bus         (bus.seq)
	);

	// Operand and opcode capture
	operandEntry i_operandEntry
	(
		.clk         (clk),
		.arstN       (arstN),
		.digitStrobe (digitStrobe),
		.digit       (digit),
		.opCode      (opCode),
		.bus         (bus.entry)
	);

	// Registers and arithmetic
	calcMailbox i_calcMailbox
	(
		.clk   (clk),
		.arstN (arstN),
		.bus   (bus.mailbox)
	);

	// Phase flags out
	assign num1Active  = bus.capNum1;
	assign num2Active  = bus.capNum2;
	assign opActive    = bus.capOp;
	assign resultValid = bus.showResult;
	// Read port sits on the result outside store cycles
	assign result      = bus.rdData;

endmodule

//--- test/calcTb.sv
`timescale 1ns/1ns
`include "calc_macros.svh"

module calcTb import calcPkg::*; ();

	localparam int resetCycles = 2;
	localparam int numSessions = 16;
	// Worst case cycles for one keystroke session
	localparam int sessionBound = 300;

	logic clk;
	logic arstN;
	logic digitStrobe;
	logic [3:0] digit;
	logic keyPress;
	calcOp opCode;
	logic num1Active;
	logic num2Active;
	logic opActive;
	logic resultValid;
	logic [`CALC_DATA_W-1:0] result;

	// Reference model state
	logic [`CALC_DATA_W-1:0] expResult;
	int seed;

	// Key level one edge back, mirrors the DUT edge detector
	logic keyQ;
	logic keyRise;
	logic cleanKey;
	logic anyFlag;

	calcTop i_calcTop
	(
		.clk         (clk),
		.arstN       (arstN),
		.digitStrobe (digitStrobe),
		.digit       (digit),
		.keyPress    (keyPress),
		.opCode      (opCode),
		.num1Active  (num1Active),
		.num2Active  (num2Active),
		.opActive    (opActive),
		.resultValid (resultValid),
		.result      (result)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			keyQ <= 1'b0;
		else
			keyQ <= keyPress;
	end

	assign keyRise  = keyPress && !keyQ;
	// Key edge not swallowed by a digit
	assign cleanKey = keyRise && !digitStrobe;
	assign anyFlag  = num1Active || num2Active || opActive || resultValid;

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "run stopped");
	endtask

	function automatic int randBelow(input int n);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return r % n;
	endfunction

	// Four functions, all modulo 2^32, zero divisor gives all ones
	function automatic logic [`CALC_DATA_W-1:0] expectedResult(
		input logic [`CALC_DATA_W-1:0] a,
		input logic [`CALC_DATA_W-1:0] b,
		input calcOp op
	);
		case (op)
			opAdd:
				return a + b;
			opSub:
				return a - b;
			opMul:
				return a * b;
			default:
				return (b == '0) ? '1 : a / b;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	resetQuiet: assert property (@(posedge clk) !arstN |-> !anyFlag)
		else failRun($sformatf("FAIL %0t: phase flag high during reset", $time));

	firstEdgeQuiet: assert property (@(posedge clk) $rose(arstN) |-> !anyFlag)
		else failRun($sformatf("FAIL %0t: phase flag high on first edge", $time));

	num1AfterReset: assert property (@(posedge clk) $rose(arstN) |=> num1Active)
		else failRun($sformatf("FAIL %0t: num1Active did not rise after reset", $time));

	flagsExclusive: assert property (@(posedge clk) disable iff (!arstN)
		$onehot0({num1Active, num2Active, opActive, resultValid}))
		else failRun($sformatf("FAIL %0t: more than one phase flag high", $time));

	// Every advance needs its own fresh key edge, held keys count once
	num2Advance: assert property (@(posedge clk) disable iff (!arstN)
		$rose(num2Active) == $past(cleanKey && num1Active, 2))
		else failRun($sformatf("FAIL %0t: second operand phase out of step", $time));

	opAdvance: assert property (@(posedge clk) disable iff (!arstN)
		$rose(opActive) == $past(cleanKey && num2Active, 2))
		else failRun($sformatf("FAIL %0t: operator phase out of step", $time));

	// Rise lands on the fourth edge after the key sample, seen one edge later
	resultLatency: assert property (@(posedge clk) disable iff (!arstN)
		$rose(resultValid) == $past(cleanKey && opActive, 5))
		else failRun($sformatf("FAIL %0t: resultValid not four cycles after key", $time));

	// Digit with a key edge keeps the phase
	digitHolds1: assert property (@(posedge clk) disable iff (!arstN)
		$past(keyRise && digitStrobe && num1Active, 2) |-> num1Active)
		else failRun($sformatf("FAIL %0t: digit and key left first operand", $time));

	digitHolds2: assert property (@(posedge clk) disable iff (!arstN)
		$past(keyRise && digitStrobe && num2Active, 2) |-> num2Active)
		else failRun($sformatf("FAIL %0t: digit and key left second operand", $time));

	resultMatch: assert property (@(posedge clk) disable iff (!arstN)
		resultValid |-> (result == expResult))
		else failRun($sformatf("FAIL %0t: result %0h, expected %0h", $time, result, expResult));

	resultSteady: assert property (@(posedge clk) disable iff (!arstN)
		(resultValid && $past(resultValid)) |-> $stable(result))
		else failRun($sformatf("FAIL %0t: result moved while valid", $time));

	////////////////////////////////////////////////////////////
	// Keystroke stimulus
	////////////////////////////////////////////////////////////

	// One-cycle digit pulse, optionally with a key rise on the same edge
	task automatic pulseDigit(input int d, input logic withKey);
		@(posedge clk);
		digitStrobe <= 1'b1;
		digit <= 4'(d);
		if (withKey)
			keyPress <= 1'b1;
		@(posedge clk);
		digitStrobe <= 1'b0;
	endtask

	task automatic releaseKey(input int hold);
		repeat (hold)
			@(posedge clk);
		keyPress <= 1'b0;
	endtask

	task automatic pressKey(input int hold);
		@(posedge clk);
		keyPress <= 1'b1;
		releaseKey(hold);
	endtask

	// Digits of one operand, then the key that ends its phase
	task automatic enterOperand(input int count, input logic zeros,
		output logic [`CALC_DATA_W-1:0] value);
		int d;
		logic collide;
		value = '0;
		collide = (randBelow(3) == 0);
		for (int i = 0; i < count; i++)
		begin
			d = zeros ? 0 : randBelow(10);
			value = value * 32'd10 + 32'(d);
			repeat (randBelow(3))
				@(posedge clk);
			pulseDigit(d, collide && (i == count - 1));
		end
		// Swallowed key edge, release and press again
		if (collide)
			releaseKey(randBelow(3));
		pressKey(1 + randBelow(5));
	endtask

	task automatic runSession(input int k);
		logic [`CALC_DATA_W-1:0] a;
		logic [`CALC_DATA_W-1:0] b;
		calcOp op;
		op = calcOp'(k[1:0]);
		while (!num1Active)
			@(negedge clk);
		enterOperand(1 + randBelow(12), 1'b0, a);
		while (!num2Active)
			@(negedge clk);
		// Two division sessions get a zero divisor
		if (k % 8 == 7)
			enterOperand(1 + randBelow(3), 1'b1, b);
		else
			enterOperand(1 + randBelow(12), 1'b0, b);
		while (!opActive)
			@(negedge clk);
		expResult = expectedResult(a, b, op);
		@(posedge clk);
		opCode <= op;
		pressKey(1 + randBelow(4));
		while (!resultValid)
			@(negedge clk);
		repeat (1 + randBelow(4))
			@(negedge clk);
		// Back to a fresh first operand
		pressKey(1 + randBelow(3));
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial
	begin
		seed = 36;
		expResult = '0;
		arstN = 1'b0;
		digitStrobe = 1'b0;
		digit = 4'd0;
		keyPress = 1'b0;
		opCode = opAdd;
		repeat (resetCycles)
			@(posedge clk);
		arstN <= 1'b1;
		for (int k = 0; k < numSessions; k++)
			runSession(k);
		repeat (4)
			@(posedge clk);
		$display("Verification passed");
		$finish;
	end

	initial
	begin
		repeat (resetCycles + numSessions * sessionBound)
			@(posedge clk);
		failRun("Timeout: the sessions did not finish within the cycle budget");
	end

endmodule

//--- sim.f
+incdir+common
common/calcPkg.sv
common/calcBusIf.sv
sequencer/calcSequencer.sv
verilog/operandEntry.sv
alu/calcMailbox.sv
verilog/calcTop.sv
test/calcTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module calcTb -Mdir obj_dir -f sim.f

# Keep going after a failing run so its output is shown
output=$(./obj_dir/VcalcTb 2>&1) || true
echo "$output"

if grep -qx "Verification passed" <<< "$output"; then
	exit 0
else
	echo "Simulation did not report a pass"
	exit 1
fi
